/* compile.f */
+incdir+common
common/rv_pkg.sv
fetch/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/rv_core_top.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F -- '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb
    import rv_pkg::*;
;

    typedef logic [31:0][`XLEN-1:0] reg_state_t;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 5;
    localparam int READ_CYCLES  = 4 * (2**`REG_ADDR_W);
    localparam int TEST_CYCLES  = RESET_CYCLES + 5 * `IMEM_WORDS + 24 + READ_CYCLES;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 200;

    logic                   clk_i;
    logic                   reset;
    logic [7:0]             instr_i;
    logic [`REG_ADDR_W-1:0] dbg_addr_i;
    logic [1:0]             byte_sel_i;
    logic [7:0]             value_o;
    logic                   running_o;

    integer      seed = 5;
    logic [31:0] prog [`IMEM_WORDS];
    int          prog_len;
    reg_state_t  exp_regs;
    int          checks = 0;
    int          case_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    event        check_go;
    event        check_done;

    rv_core_top dut0 (
        .clk_i      (clk_i),
        .reset      (reset),
        .instr_i    (instr_i),
        .dbg_addr_i (dbg_addr_i),
        .byte_sel_i (byte_sel_i),
        .value_o    (value_o),
        .running_o  (running_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic bit has_end_byte(input logic [31:0] w);
        bit hit;
        hit = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (w[b*8 +: 8] == `LOAD_END_BYTE) hit = 1'b1;
        end
        return hit;
    endfunction

    // in-order ISA model of the supported OP and OP-IMM subset
    function automatic reg_state_t run_reference(input int len);
        reg_state_t  regs;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [6:0]  opc;
        logic        known;
        alu_op_e     op;
        regs = '0;
        for (int i = 0; i < len; i++) begin
            ins   = prog[i];
            opc   = ins[6:0];
            known = (opc == `OPC_OP) || (opc == `OPC_OP_IMM);
            op    = ALU_ADD;
            case (ins[14:12])
                3'b000:  op = (opc == `OPC_OP && ins[30]) ? ALU_SUB : ALU_ADD;
                3'b010:  op = ALU_SLT;
                3'b100:  op = ALU_XOR;
                3'b110:  op = ALU_OR;
                3'b111:  op = ALU_AND;
                default: known = 1'b0;                    // shifts and sltu
            endcase
            a = regs[ins[19:15]];
            b = (opc == `OPC_OP_IMM) ? {{20{ins[31]}}, ins[31:20]} : regs[ins[24:20]];
            case (op)
                ALU_SUB: res = a - b;
                ALU_AND: res = a & b;
                ALU_OR:  res = a | b;
                ALU_XOR: res = a ^ b;
                ALU_SLT: res = {31'b0, $signed(a) < $signed(b)};
                default: res = a + b;
            endcase
            if (known && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
        end
        return regs;
    endfunction

    task automatic clear_program();
        for (int i = 0; i < `IMEM_WORDS; i++) prog[i] = '0;
        prog_len = 0;
    endtask

    task automatic append_instr(input logic [31:0] w);
        prog[prog_len] = w;                           // last word stays zero
        prog_len++;
    endtask

    task automatic gen_random_program(input int len);
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        clear_program();
        for (int i = 0; i < len; i++) begin
            do begin
                kind = int'($unsigned($random(seed)) % 11);
                rd   = 5'($unsigned($random(seed)) % 8);   // small set for many hazards
                rs1  = 5'($unsigned($random(seed)) % 8);
                rs2  = 5'($unsigned($random(seed)) % 8);
                imm  = 12'($unsigned($random(seed)));
                case (kind)
                    0:  w = encode_r(7'h00, rs2, rs1, 3'b000, rd);
                    1:  w = encode_r(7'h20, rs2, rs1, 3'b000, rd);
                    2:  w = encode_r(7'h00, rs2, rs1, 3'b111, rd);
                    3:  w = encode_r(7'h00, rs2, rs1, 3'b110, rd);
                    4:  w = encode_r(7'h00, rs2, rs1, 3'b100, rd);
                    5:  w = encode_r(7'h00, rs2, rs1, 3'b010, rd);
                    6:  w = encode_i(imm, rs1, 3'b000, rd, `OPC_OP_IMM);
                    7:  w = encode_i(imm, rs1, 3'b111, rd, `OPC_OP_IMM);
                    8:  w = encode_i(imm, rs1, 3'b110, rd, `OPC_OP_IMM);
                    9:  w = encode_i(imm, rs1, 3'b100, rd, `OPC_OP_IMM);
                    default: w = encode_i(imm, rs1, 3'b010, rd, `OPC_OP_IMM);
                endcase
            end while (has_end_byte(w));
            append_instr(w);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        @(posedge clk_i);
        instr_i <= `LOAD_BEGIN_BYTE;
        for (int i = 0; i < prog_len; i++) begin
            for (int b = 0; b < 4; b++) begin
                @(posedge clk_i);
                instr_i <= prog[i][b*8 +: 8];         // little-endian
            end
        end
        @(posedge clk_i);
        instr_i <= `LOAD_END_BYTE;
        @(posedge clk_i);
        instr_i <= 8'h00;
    endtask

    task automatic compare_all();
        -> check_go;
        @(check_done);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errs += case_errs;
        if (case_errs != 0) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (case_errs == 0) ? "ok" : "failed");
        case_errs = 0;
    endtask

    task automatic run_program(input string name);
        int waited;
        waited = 0;
        apply_reset();
        load_program();
        @(negedge clk_i);
        while (!running_o && waited < 8) begin
            @(negedge clk_i);
            waited++;
        end
        checks++;
        assert (running_o) else begin
            $display("test %s: running_o never rose after the end byte", name);
            case_errs++;
        end
        repeat (prog_len + 8) @(posedge clk_i);
        exp_regs = run_reference(prog_len);
        compare_all();
        report_test(name);
    endtask

    // reads every register byte and compares it with the model
    initial begin : compare_regs
        logic [7:0] want;
        forever begin
            @(check_go);
            for (int r = 0; r < 2**`REG_ADDR_W; r++) begin
                for (int b = 0; b < 4; b++) begin
                    @(posedge clk_i);
                    dbg_addr_i <= 5'(r);
                    byte_sel_i <= 2'(b);
                    @(negedge clk_i);
                    want = exp_regs[r][b*8 +: 8];
                    checks++;
                    assert (value_o == want) else begin
                        $display("ERR %0t: x%0d byte %0d reads %02h, expected %02h",
                                 $time, r, b, value_o, want);
                        case_errs++;
                    end
                end
            end
            -> check_done;
        end
    end

    initial begin : run_tests
        reset      = 1'b1;
        instr_i    = 8'h00;
        dbg_addr_i = '0;
        byte_sel_i = 2'd0;

        // state right after reset
        apply_reset();
        @(negedge clk_i);
        checks++;
        assert (running_o == 1'b0) else begin
            $display("ERR %0t: running_o is %b after reset, expected 0", $time, running_o);
            case_errs++;
        end
        exp_regs = '0;
        compare_all();
        report_test("reset");

        gen_random_program(20);
        run_program("random");

        // dependency chain at distances 1, 2 and 3
        clear_program();
        append_instr(encode_i(12'd100, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
        append_instr(encode_i(12'hF9C, 5'd1, 3'b000, 5'd2, `OPC_OP_IMM));   // -100
        append_instr(encode_i(12'h055, 5'd0, 3'b100, 5'd3, `OPC_OP_IMM));
        append_instr(encode_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
        append_instr(encode_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd5));
        append_instr(encode_r(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
        append_instr(encode_r(7'h00, 5'd0, 5'd4, 3'b010, 5'd7));
        append_instr(encode_r(7'h00, 5'd6, 5'd7, 3'b100, 5'd8));
        append_instr(encode_r(7'h00, 5'd5, 5'd8, 3'b111, 5'd9));
        append_instr(encode_i(12'h7FF, 5'd9, 3'b010, 5'd10, `OPC_OP_IMM));
        run_program("forwarding");

        // x0 writes and unknown opcodes
        clear_program();
        append_instr(encode_i(12'h123, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
        append_instr(encode_i(12'h077, 5'd0, 3'b000, 5'd0, `OPC_OP_IMM));
        append_instr(encode_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        append_instr(encode_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));
        append_instr(encode_i(12'h456, 5'd1, 3'b010, 5'd1, 7'b0000011));     // load
        append_instr(encode_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd3));             // sll
        append_instr(encode_i(12'h321, 5'd0, 3'b000, 5'd4, 7'b1101111));     // jal
        append_instr(encode_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd5));
        run_program("x0_unknown");

        // x1 ends at 0x003a54c6 so every byte differs
        clear_program();
        append_instr(encode_i(12'h3A5, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
        repeat (12) append_instr(encode_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
        append_instr(encode_i(12'h4C6, 5'd1, 3'b000, 5'd1, `OPC_OP_IMM));
        append_instr(encode_i(12'h800, 5'd1, 3'b100, 5'd2, `OPC_OP_IMM));
        append_instr(encode_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd3));
        run_program("byte_select");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rv_core_assert.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_core_assert (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic                   running_o,
    input  logic [`REG_ADDR_W-1:0] dbg_addr_i,
    input  logic [7:0]             value_o
);

    // running is sticky once set
    running_sticky: assert property (
        @(posedge clk_i) disable iff (reset) running_o |=> running_o
    ) else $error("running_o fell while reset was low");

    // x0 is hardwired
    x0_reads_zero: assert property (
        @(posedge clk_i) (dbg_addr_i == '0) |-> (value_o == 8'h00)
    ) else $error("debug read of x0 returned a nonzero byte");

    idle_in_reset: assert property (
        @(posedge clk_i) reset |-> !running_o
    ) else $error("running_o high while reset was asserted");

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk_i      (clk_i),
    .reset      (reset),
    .running_o  (running_o),
    .dbg_addr_i (dbg_addr_i),
    .value_o    (value_o)
);

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_core_top
    import rv_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic [7:0]             instr_i,    // loader byte stream
    input  logic [`REG_ADDR_W-1:0] dbg_addr_i,
    input  logic [1:0]             byte_sel_i,
    output logic [7:0]             value_o,
    output logic                   running_o
);

    if_id_t                 if_id;
    id_ex_t                 id_ex;
    ex_wb_t                 ex_wb;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    fetch_unit u_fetch (
        .clk_i     (clk_i),
        .reset     (reset),
        .instr_i   (instr_i),
        .if_id_o   (if_id),
        .running_o (running_o)
    );

    decode_unit u_decode (
        .clk_i      (clk_i),
        .reset      (reset),
        .if_id_i    (if_id),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    reg_file u_regs (
        .clk_i      (clk_i),
        .reset      (reset),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (ex_wb.we),          // writeback port
        .rd_addr_i  (ex_wb.rd),
        .rd_data_i  (ex_wb.result),
        .dbg_addr_i (dbg_addr_i),
        .byte_sel_i (byte_sel_i),
        .value_o    (value_o)
    );

    execute_unit u_exec (
        .clk_i   (clk_i),
        .reset   (reset),
        .id_ex_i (id_ex),
        .ex_wb_o (ex_wb)
    );

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module execute_unit
    import rv_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset,
    input  id_ex_t id_ex_i,
    output ex_wb_t ex_wb_o
);

    logic             fwd_a;
    logic             fwd_b;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;
    logic             lt;

    // previous instruction still sits in ex_wb
    assign fwd_a = ex_wb_o.we && (ex_wb_o.rd != '0) && (ex_wb_o.rd == id_ex_i.rs1);
    assign fwd_b = ex_wb_o.we && (ex_wb_o.rd != '0) && (ex_wb_o.rd == id_ex_i.rs2);

    assign src_a = fwd_a ? ex_wb_o.result : id_ex_i.rs1_data;
    assign src_b = fwd_b ? ex_wb_o.result : id_ex_i.rs2_data;
    assign op_b  = id_ex_i.imm_sel ? id_ex_i.imm : src_b;
    assign lt    = $signed(src_a) < $signed(op_b);

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = src_a + op_b;
            ALU_SUB: result = src_a - op_b;
            ALU_AND: result = src_a & op_b;
            ALU_OR:  result = src_a | op_b;
            ALU_XOR: result = src_a ^ op_b;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, lt};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_wb_o <= '0;
        end else begin
            ex_wb_o.we     <= id_ex_i.valid && id_ex_i.we;
            ex_wb_o.rd     <= id_ex_i.rd;
            ex_wb_o.result <= result;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    input  logic [`REG_ADDR_W-1:0] dbg_addr_i,
    input  logic [1:0]             byte_sel_i,
    output logic [7:0]             value_o
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];
    logic [`XLEN-1:0] dbg_word;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;         // x0 never written
        end
    end

    // write-through on a same-cycle read
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

    assign dbg_word = regs[dbg_addr_i];
    assign value_o  = dbg_word[byte_sel_i*8 +: 8];  // 0 selects lsb

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module decode_unit
    import rv_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset,
    input  if_id_t                 if_id_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output id_ex_t                 id_ex_o
);

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   funct7_5;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    logic                   supported;
    logic                   imm_sel;
    alu_op_e                alu_op;

    assign opcode     = if_id_i.instr[6:0];
    assign rd         = if_id_i.instr[11:7];
    assign funct3     = if_id_i.instr[14:12];
    assign funct7_5   = if_id_i.instr[30];   // sub vs add
    assign rs1_addr_o = if_id_i.instr[19:15];
    assign rs2_addr_o = if_id_i.instr[24:20];
    assign imm        = {{(`XLEN-12){if_id_i.instr[31]}}, if_id_i.instr[31:20]};

    always_comb begin
        alu_op    = ALU_ADD;
        supported = 1'b0;
        imm_sel   = (opcode == `OPC_OP_IMM);
        if ((opcode == `OPC_OP) || (opcode == `OPC_OP_IMM)) begin
            supported = 1'b1;
            case (funct3)
                F3_ADD: alu_op = (opcode == `OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
                F3_SLT: alu_op = ALU_SLT;
                F3_XOR: alu_op = ALU_XOR;
                F3_OR:  alu_op = ALU_OR;
                F3_AND: alu_op = ALU_AND;
                default: supported = 1'b0;   // shifts, sltu retire as no-op
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid    <= if_id_i.valid;
            id_ex_o.we       <= if_id_i.valid && supported && (rd != '0);
            id_ex_o.rd       <= rd;
            id_ex_o.rs1      <= rs1_addr_o;
            id_ex_o.rs2      <= rs2_addr_o;
            id_ex_o.rs1_data <= rs1_data_i;
            id_ex_o.rs2_data <= rs2_data_i;
            id_ex_o.imm      <= imm;
            id_ex_o.imm_sel  <= imm_sel;
            id_ex_o.alu_op   <= alu_op;
        end
    end

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module fetch_unit
    import rv_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset,
    input  logic [7:0] instr_i,
    output if_id_t     if_id_o,
    output logic       running_o
);

    localparam int IMEM_BYTES = `IMEM_WORDS * 4;
    localparam int BPTR_W     = $clog2(IMEM_BYTES);
    localparam int PC_W       = $clog2(`IMEM_WORDS);
    localparam logic [PC_W-1:0] PC_LAST = PC_W'(`IMEM_WORDS - 1);

    logic              loading;                  // between begin and end bytes
    logic              running;
    logic [BPTR_W-1:0] wr_ptr;                   // byte address
    logic [PC_W-1:0]   pc;                       // word address
    logic              byte_we;
    logic [`XLEN-1:0]  imem [`IMEM_WORDS];

    assign byte_we   = loading && (instr_i != `LOAD_END_BYTE);
    assign running_o = running;

    // loader control
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            loading <= 1'b0;
            running <= 1'b0;
            wr_ptr  <= '0;
        end else if (loading) begin
            if (instr_i == `LOAD_END_BYTE) begin
                loading <= 1'b0;
                running <= 1'b1;                 // sticky until reset
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end else if (!running && (instr_i == `LOAD_BEGIN_BYTE)) begin
            loading <= 1'b1;
        end
    end

    // little-endian byte writes into word memory
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                imem[i] <= '0;
            end
        end else if (byte_we) begin
            imem[wr_ptr[BPTR_W-1:2]][wr_ptr[1:0]*8 +: 8] <= instr_i;
        end
    end

    // program counter and fetch/decode register
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            if_id_o <= '0;
        end else if (running) begin
            if_id_o.valid <= 1'b1;
            if_id_o.instr <= imem[pc];
            if (pc != PC_LAST) begin
                pc <= pc + 1'b1;                 // holds on last word
            end
        end
    end

endmodule

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5              // signed compare
    } alu_op_e;

    // fetch -> decode
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       instr;
    } if_id_t;

    // decode -> execute
    typedef struct packed {
        logic                   valid;
        logic                   we;     // already masked for x0 and no-ops
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;    // sign-extended I-type
        logic                   imm_sel;
        alu_op_e                alu_op;
    } id_ex_t;

    // execute -> writeback
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
    } ex_wb_t;

endpackage

`default_nettype wire

/* common/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and register addressing
`define XLEN 32
`define REG_ADDR_W 5

// instruction memory depth in 32-bit words
`define IMEM_WORDS 32

// executed opcode groups
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011

// byte loader control values on instr_i
`define LOAD_BEGIN_BYTE 8'hFE
`define LOAD_END_BYTE 8'hFF

`endif
